/* soc_pkg.sv */
/*
 * shared constants for the memory-bus fabric
 * region codes, register offsets, sizes, fixed read values
 */
`default_nettype none

package soc_pkg;

	// top address nibble of each mapped region
	localparam logic [3:0] region_sys = 4'h2;
	localparam logic [3:0] region_ram = 4'h4;

	// system register word offsets, address bits 3..2
	localparam logic [1:0] reg_off_led   = 2'd0;
	localparam logic [1:0] reg_off_psram = 2'd1;
	localparam logic [1:0] reg_off_spare = 2'd2;
	localparam logic [1:0] reg_off_run   = 2'd3;

	// fixed read values
	localparam logic [31:0] soc_version  = 32'h0000_8000;
	localparam logic [31:0] bus_err_data = 32'hdead_beef;

	// irq 0..2 belong to the cpu itself
	localparam int irq_bus_err = 3;

	// scratch ram geometry, in words
	localparam int ram_words = 256;
	localparam int ram_aw    = 8;

	// system register widths
	localparam int led_w    = 6;
	localparam int core_cnt = 2;
	localparam int ovr_w    = 8;

endpackage

`default_nettype wire

/* bus_decode.sv */
/*
 * address decode for the master bus
 * one select per mapped region, bus error for the rest
 */
`default_nettype none

module bus_decode import soc_pkg::*; (
	input  logic        mem_valid,
	input  logic [31:0] mem_addr,
	output logic        sys_sel,
	output logic        ram_sel,
	output logic        bus_err
);

	logic [3:0] region;
	logic       hit_sys;
	logic       hit_ram;

	// regions are 256 MB apart
	assign region = mem_addr[31:28];

	always_comb begin
		hit_sys = (region == region_sys);
		hit_ram = (region == region_ram);

		sys_sel = mem_valid && hit_sys;
		ram_sel = mem_valid && hit_ram;

		// anything valid that lands nowhere
		bus_err = mem_valid && !hit_sys && !hit_ram;
	end

endmodule

`default_nettype wire

/* sys_regs.sv */
/*
 * word register block: leds, psram pin override, core run bits
 * plus the psram pin multiplexer
 */
`default_nettype none

module sys_regs import soc_pkg::*; (
	input  logic                clk48m,
	input  logic                rst,
	input  logic                sys_sel,
	input  logic [31:0]         mem_addr,
	input  logic [31:0]         mem_wdata,
	input  logic [3:0]          mem_wstrb,
	input  logic                qpi_sclk,
	input  logic                qpi_nce,
	input  logic                qpi_oe,
	input  logic [3:0]          qpi_sout,
	output logic [31:0]         sys_rdata,
	output logic [led_w-1:0]    led,
	output logic [core_cnt-1:0] core_run,
	output logic                psram_sclk,
	output logic                psram_nce,
	output logic                psram_oe,
	output logic [3:0]          psram_sout
);

	logic [1:0]          offset;
	logic                wr_en;
	logic [ovr_w-1:0]    psram_ovr;
	logic [core_cnt-1:1] run_hi;
	logic                ovr_on;

	assign offset = mem_addr[3:2];
	// only the low byte lane carries register writes
	assign wr_en = sys_sel && mem_wstrb[0];

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led <= '0;
			psram_ovr <= '0;
			run_hi <= '1;
		end else if (wr_en) begin
			case (offset)
				reg_off_led:   led <= mem_wdata[led_w-1:0];
				reg_off_psram: psram_ovr <= mem_wdata[ovr_w-1:0];
				reg_off_run:   run_hi <= mem_wdata[core_cnt-1:1];
				default:       ;
			endcase
		end
	end

	// core 0 is never held
	assign core_run = {run_hi, 1'b1};

	always_comb begin
		sys_rdata = '0;
		case (offset)
			reg_off_led:   sys_rdata = soc_version;
			reg_off_psram: sys_rdata[ovr_w-1:0] = psram_ovr;
			reg_off_spare: sys_rdata = '0;
			reg_off_run:   sys_rdata[core_cnt-1:0] = core_run;
			default:       sys_rdata = '0;
		endcase
	end

	// bit 7 hands the pins to software
	assign ovr_on = psram_ovr[7];

	always_comb begin
		if (ovr_on) begin
			psram_oe   = psram_ovr[6];
			psram_sclk = psram_ovr[5];
			psram_nce  = psram_ovr[4];
			psram_sout = psram_ovr[3:0];
		end else begin
			psram_oe   = qpi_oe;
			psram_sclk = qpi_sclk;
			psram_nce  = qpi_nce;
			psram_sout = qpi_sout;
		end
	end

endmodule

`default_nettype wire

/* scratch_ram.sv */
/*
 * byte-strobed scratch word ram
 * answers one cycle after selection, one request at a time
 */
`default_nettype none

module scratch_ram import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        ram_sel,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	input  logic [3:0]  mem_wstrb,
	output logic [31:0] ram_rdata,
	output logic        ram_ready
);

	logic [31:0]       mem [ram_words];
	logic [ram_aw-1:0] idx;
	logic              busy;
	logic              wr_en;

	assign idx = mem_addr[ram_aw+1:2];

	// busy marks the answer cycle, then drops for one cycle
	always_ff @(posedge clk48m) begin
		if (rst) begin
			busy <= 1'b0;
		end else begin
			busy <= ram_sel && !busy;
		end
	end

	assign ram_ready = busy;

	// writes land at the end of the answer cycle
	assign wr_en = busy && ram_sel;

	always_ff @(posedge clk48m) begin
		for (int b = 0; b < 4; b++) begin
			if (wr_en && mem_wstrb[b])
				mem[idx][8*b +: 8] <= mem_wdata[8*b +: 8];
		end
	end

	always_ff @(posedge clk48m) begin
		if (ram_sel && !busy)
			ram_rdata <= mem[idx];
	end

	// master must hold valid until it sees ready
	a_ready_needs_sel: assert property (
		@(posedge clk48m) disable iff (rst) ram_ready |-> ram_sel
	) else $error("scratch ram ready without a held request");

endmodule

`default_nettype wire

/* bus_return.sv */
/*
 * return path to the master
 * ready and read data merge, interrupt vector register
 */
`default_nettype none

module bus_return import soc_pkg::*; (
	input  logic        clk48m,
	input  logic        rst,
	input  logic        sys_sel,
	input  logic        ram_sel,
	input  logic        bus_err,
	input  logic [31:0] sys_rdata,
	input  logic [31:0] ram_rdata,
	input  logic        ram_ready,
	output logic        mem_ready,
	output logic [31:0] mem_rdata,
	output logic [31:0] irq
);

	// registers and errors answer at once, ram after its wait state
	assign mem_ready = sys_sel || bus_err || ram_ready;

	always_comb begin
		if (sys_sel)
			mem_rdata = sys_rdata;
		else if (ram_sel)
			mem_rdata = ram_rdata;
		else if (bus_err)
			mem_rdata = bus_err_data;
		else
			mem_rdata = '0;
	end

	// one-cycle pulse per error cycle
	always_ff @(posedge clk48m) begin
		if (rst) begin
			irq <= '0;
		end else begin
			irq <= '0;
			irq[irq_bus_err] <= bus_err;
		end
	end

	// a late ram answer must not overlap an immediate one
	a_single_source: assert property (
		@(posedge clk48m) disable iff (rst) ram_ready |-> !(sys_sel || bus_err)
	) else $error("two targets answered in the same cycle");

endmodule

`default_nettype wire

/* soc_fabric.sv */
/*
 * memory-bus fabric top
 * decode, system registers, scratch ram and return path
 */
`default_nettype none

module soc_fabric import soc_pkg::*; (
	input  logic                clk48m,
	input  logic                rst,
	input  logic                mem_valid,
	input  logic [31:0]         mem_addr,
	input  logic [31:0]         mem_wdata,
	input  logic [3:0]          mem_wstrb,
	output logic                mem_ready,
	output logic [31:0]         mem_rdata,
	output logic [31:0]         irq,
	output logic [led_w-1:0]    led,
	output logic [core_cnt-1:0] core_run,
	input  logic                qpi_sclk,
	input  logic                qpi_nce,
	input  logic                qpi_oe,
	input  logic [3:0]          qpi_sout,
	output logic                psram_sclk,
	output logic                psram_nce,
	output logic                psram_oe,
	output logic [3:0]          psram_sout
);

	logic        sys_sel;
	logic        ram_sel;
	logic        bus_err;
	logic [31:0] sys_rdata;
	logic [31:0] ram_rdata;
	logic        ram_ready;

	bus_decode decode_i (
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.sys_sel   (sys_sel),
		.ram_sel   (ram_sel),
		.bus_err   (bus_err)
	);

	sys_regs regs_i (
		.clk48m     (clk48m),
		.rst        (rst),
		.sys_sel    (sys_sel),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wstrb  (mem_wstrb),
		.qpi_sclk   (qpi_sclk),
		.qpi_nce    (qpi_nce),
		.qpi_oe     (qpi_oe),
		.qpi_sout   (qpi_sout),
		.sys_rdata  (sys_rdata),
		.led        (led),
		.core_run   (core_run),
		.psram_sclk (psram_sclk),
		.psram_nce  (psram_nce),
		.psram_oe   (psram_oe),
		.psram_sout (psram_sout)
	);

	scratch_ram ram_i (
		.clk48m    (clk48m),
		.rst       (rst),
		.ram_sel   (ram_sel),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.ram_rdata (ram_rdata),
		.ram_ready (ram_ready)
	);

	bus_return return_i (
		.clk48m    (clk48m),
		.rst       (rst),
		.sys_sel   (sys_sel),
		.ram_sel   (ram_sel),
		.bus_err   (bus_err),
		.sys_rdata (sys_rdata),
		.ram_rdata (ram_rdata),
		.ram_ready (ram_ready),
		.mem_ready (mem_ready),
		.mem_rdata (mem_rdata),
		.irq       (irq)
	);

endmodule

`default_nettype wire

/* tb_checker.sv */
/*
 * testbench watcher for the fabric ports
 * compares read data, wait states, irq pulses, leds, run bits and psram pins
 */
`default_nettype none

module tb_checker import soc_pkg::*; (
	input  logic                clk48m,
	input  logic                rst,
	input  logic                mem_valid,
	input  logic                mem_ready,
	input  logic [31:0]         mem_rdata,
	input  logic [31:0]         irq,
	input  logic [led_w-1:0]    led,
	input  logic [core_cnt-1:0] core_run,
	input  logic [6:0]          qpi_pins,
	input  logic [6:0]          psram_pins,
	input  logic                acc_read,
	input  logic                acc_err,
	input  int                  exp_wait,
	input  logic [31:0]         exp_data,
	input  logic                chk_idle,
	input  logic                chk_led,
	input  logic                chk_run,
	input  logic                chk_pins,
	input  int                  vec_done,
	output int                  vec_pass,
	output int                  vec_fail,
	output int                  err_total
);

	timeunit 1ns;
	timeprecision 1ps;

	int          wait_cnt;
	int          vec_errs;
	int          seen;
	logic        prev_err;
	logic [31:0] exp_irq;

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
		vec_errs++;
	endtask

	task automatic plain_error(input string msg);
		$display("%s at %0t", msg, $time);
		vec_errs++;
	endtask

	// mid-cycle sampling, inputs change 1 ns after the rising edge
	always @(negedge clk48m) begin
		if (rst) begin
			wait_cnt = 0;
			vec_errs = 0;
			seen = 0;
			prev_err = 1'b0;
			vec_pass = 0;
			vec_fail = 0;
			err_total = 0;
		end else begin
			// irq bit 3 exactly one cycle after each unmapped access cycle
			exp_irq = '0;
			exp_irq[irq_bus_err] = prev_err;
			if (irq !== exp_irq)
				value_error("irq", irq, exp_irq);
			prev_err = mem_valid && acc_err;

			if (mem_ready && !mem_valid)
				plain_error("mem_ready is high with no request pending");

			if (mem_valid && mem_ready) begin
				if (wait_cnt != exp_wait)
					plain_error($sformatf("access answered after %0d wait cycles, expected %0d",
						wait_cnt, exp_wait));
				if (acc_read && mem_rdata !== exp_data)
					value_error("mem_rdata", mem_rdata, exp_data);
				wait_cnt = 0;
			end else if (mem_valid) begin
				wait_cnt++;
			end

			if (chk_idle) begin
				if (mem_ready !== 1'b0)
					value_error("mem_ready", 32'(mem_ready), 32'h0);
				if (led !== '0)
					value_error("led", 32'(led), 32'h0);
				if (core_run !== '1)
					value_error("core_run", 32'(core_run), 32'({core_cnt{1'b1}}));
				if (psram_pins !== qpi_pins)
					value_error("psram_pins", 32'(psram_pins), 32'(qpi_pins));
			end
			if (chk_led && 32'(led) !== exp_data)
				value_error("led", 32'(led), exp_data);
			if (chk_run && 32'(core_run) !== exp_data)
				value_error("core_run", 32'(core_run), exp_data);
			if (chk_pins && 32'(psram_pins) !== exp_data)
				value_error("psram_pins", 32'(psram_pins), exp_data);

			// one line per finished vector
			if (vec_done != seen) begin
				seen++;
				err_total += vec_errs;
				if (vec_errs == 0) begin
					vec_pass++;
					$display("vector %0d: ok", seen);
				end else begin
					vec_fail++;
					$display("vector %0d: FAIL with %0d errors", seen, vec_errs);
				end
				vec_errs = 0;
			end
		end
	end

endmodule

`default_nettype wire

/* tb_top.sv */
/*
 * testbench top for the memory-bus fabric
 * clock, reset, vector reader, bus driver and ram reference copy
 */
`default_nettype none

module tb_top import soc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                clk48m = 1'b0;
	logic                rst;
	logic                mem_valid;
	logic [31:0]         mem_addr;
	logic [31:0]         mem_wdata;
	logic [3:0]          mem_wstrb;
	logic                mem_ready;
	logic [31:0]         mem_rdata;
	logic [31:0]         irq;
	logic [led_w-1:0]    led;
	logic [core_cnt-1:0] core_run;
	logic                qpi_sclk;
	logic                qpi_nce;
	logic                qpi_oe;
	logic [3:0]          qpi_sout;
	logic                psram_sclk;
	logic                psram_nce;
	logic                psram_oe;
	logic [3:0]          psram_sout;

	// expectations handed to the checker
	logic                acc_read;
	logic                acc_err;
	int                  exp_wait;
	logic [31:0]         exp_data;
	logic                chk_idle;
	logic                chk_led;
	logic                chk_run;
	logic                chk_pins;
	int                  vec_done;
	int                  vec_pass;
	int                  vec_fail;
	int                  err_total;

	logic [31:0]         ram_model [ram_words];
	logic [31:0]         rng;
	logic                aborted;

	always #5 clk48m = ~clk48m;

	soc_fabric dut_i (.*);

	tb_checker chk_i (
		.*,
		.qpi_pins   ({qpi_oe, qpi_sclk, qpi_nce, qpi_sout}),
		.psram_pins ({psram_oe, psram_sclk, psram_nce, psram_sout})
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// one access with valid held until ready or the 20-cycle limit
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, input logic rd_chk, input logic [31:0] exp,
			input int waits, input logic is_err, output logic ok);
		int n;
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = strb;
		acc_read = rd_chk;
		acc_err = is_err;
		exp_data = exp;
		exp_wait = waits;
		ok = 1'b0;
		n = 0;
		while (!ok && n < 20) begin
			@(negedge clk48m);
			ok = mem_ready;
			n++;
		end
		@(posedge clk48m);
		#1;
		mem_valid = 1'b0;
		mem_wstrb = 4'h0;
		acc_read = 1'b0;
		acc_err = 1'b0;
		if (!ok)
			$display("timeout: no mem_ready within 20 cycles for address %h", addr);
	endtask

	task automatic ram_write(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, output logic ok);
		logic [31:0] word;
		word = ram_model[addr[ram_aw+1:2]];
		for (int b = 0; b < 4; b++) begin
			if (strb[b])
				word[8*b +: 8] = wdata[8*b +: 8];
		end
		ram_model[addr[ram_aw+1:2]] = word;
		bus_access(addr, wdata, strb, 1'b0, 32'h0, 1, 1'b0, ok);
	endtask

	// count words of xorshift data, then read all of them back
	task automatic fill_ram(input logic [31:0] base, input logic [31:0] count, output logic ok);
		logic [31:0] addr;
		ok = 1'b1;
		for (int i = 0; i < int'(count) && ok; i++) begin
			addr = base + 32'(4 * i);
			rng = xorshift32(rng);
			ram_write(addr, rng, 4'hf, ok);
		end
		for (int i = 0; i < int'(count) && ok; i++) begin
			addr = base + 32'(4 * i);
			bus_access(addr, 32'h0, 4'h0, 1'b1, ram_model[addr[ram_aw+1:2]], 1, 1'b0, ok);
		end
	endtask

	task automatic state_check(input string op, input logic [31:0] expv);
		exp_data = expv;
		chk_idle = (op == "idle");
		chk_led = (op == "led");
		chk_run = (op == "run");
		chk_pins = (op == "pin");
		@(posedge clk48m);
		#1;
		chk_idle = 1'b0;
		chk_led = 1'b0;
		chk_run = 1'b0;
		chk_pins = 1'b0;
	endtask

	task automatic run_vector(input string op, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, input logic [6:0] qpi, input logic [31:0] expv);
		logic ok;
		ok = 1'b1;
		{qpi_oe, qpi_sclk, qpi_nce, qpi_sout} = qpi;
		if (op == "rd")
			bus_access(addr, 32'h0, 4'h0, 1'b1, expv, 0, 1'b0, ok);
		else if (op == "wr")
			bus_access(addr, wdata, strb, 1'b0, 32'h0, 0, 1'b0, ok);
		else if (op == "err")
			bus_access(addr, 32'h0, 4'h0, 1'b1, expv, 0, 1'b1, ok);
		else if (op == "rw")
			ram_write(addr, wdata, strb, ok);
		else if (op == "rr")
			bus_access(addr, 32'h0, 4'h0, 1'b1, ram_model[addr[ram_aw+1:2]], 1, 1'b0, ok);
		else if (op == "fill")
			fill_ram(addr, wdata, ok);
		else if (op == "idle" || op == "led" || op == "run" || op == "pin")
			state_check(op, expv);
		else begin
			$display("unknown operation %s in vector %0d", op, vec_done + 1);
			ok = 1'b0;
		end
		if (!ok)
			aborted = 1'b1;
		vec_done++;
	endtask

	initial begin
		string       line;
		string       op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [31:0] strb;
		logic [31:0] qpi;
		logic [31:0] expv;
		int          fd;
		int          n;

		rst = 1'b1;
		mem_valid = 1'b0;
		mem_addr = '0;
		mem_wdata = '0;
		mem_wstrb = '0;
		qpi_sclk = 1'b0;
		qpi_nce = 1'b1;
		qpi_oe = 1'b0;
		qpi_sout = '0;
		acc_read = 1'b0;
		acc_err = 1'b0;
		exp_wait = 0;
		exp_data = '0;
		chk_idle = 1'b0;
		chk_led = 1'b0;
		chk_run = 1'b0;
		chk_pins = 1'b0;
		vec_done = 0;
		rng = 32'd60553;
		aborted = 1'b0;

		repeat (8) @(posedge clk48m);
		#1;
		rst = 1'b0;

		fd = $fopen("fabric_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open fabric_vectors.txt");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
				n = $sscanf(line, "%s %h %h %h %h %h", op, addr, wdata, strb, qpi, expv);
				if (n != 6) begin
					$display("malformed vector line: %s", line);
					aborted = 1'b1;
				end else begin
					run_vector(op, addr, wdata, strb[3:0], qpi[6:0], expv);
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		// the checker reports a vector in the cycle after it ends
		n = 0;
		while (vec_pass + vec_fail != vec_done && n < 10) begin
			@(posedge clk48m);
			n++;
		end
		if (vec_pass + vec_fail != vec_done)
			$display("checker reported %0d of %0d vectors", vec_pass + vec_fail, vec_done);
		$display("vectors: %0d passed, %0d failed, %0d errors", vec_pass, vec_fail, err_total);
		if (aborted || err_total != 0 || vec_fail != 0 || vec_pass + vec_fail != vec_done) begin
			$display("Test failed");
		end else begin
			$display("Test passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* fabric_vectors.txt */
// op addr wdata strobes qpi{oe,sclk,nce,sout} expected, all hex
// rr and fill take expected data from the ram copy; fill puts its word count in wdata
idle 00000000 00000000 0 35 00000000
pin  00000000 00000000 0 4a 0000004a
rd   20000000 00000000 0 00 00008000
wr   20000000 0000002d 1 00 00000000
led  00000000 00000000 0 00 0000002d
wr   20000000 00000012 e 00 00000000
led  00000000 00000000 0 00 0000002d
rd   2000000c 00000000 0 00 00000003
wr   2000000c 00000000 1 00 00000000
run  00000000 00000000 0 00 00000001
rd   2000000c 00000000 0 00 00000001
wr   2000000c 00000002 1 00 00000000
run  00000000 00000000 0 00 00000003
rd   20000008 00000000 0 00 00000000
wr   20000004 000000d6 1 00 00000000
rd   20000004 00000000 0 00 000000d6
pin  00000000 00000000 0 2b 00000056
pin  00000000 00000000 0 7f 00000056
wr   20000004 00000000 1 00 00000000
pin  00000000 00000000 0 2b 0000002b
fill 40000000 00000010 f 00 00000000
rw   40000004 a5a5a5a5 1 00 00000000
rw   40000008 c3c3c3c3 6 00 00000000
rw   4000003c 11223344 8 00 00000000
rw   40000100 0badf00d f 00 00000000
rr   40000004 00000000 0 00 00000000
rr   40000008 00000000 0 00 00000000
rr   4000003c 00000000 0 00 00000000
rr   40000100 00000000 0 00 00000000
err  80000000 00000000 0 00 deadbeef
err  10000010 00000000 0 00 deadbeef
rd   20000000 00000000 0 00 00008000
rr   40000000 00000000 0 00 00000000
rd   2000000c 00000000 0 00 00000003
rr   40000020 00000000 0 00 00000000
rd   20000004 00000000 0 00 00000000
err  f0000000 00000000 0 00 deadbeef
rr   4000003c 00000000 0 00 00000000
wr   20000000 00000015 1 00 00000000
rr   40000004 00000000 0 00 00000000
led  00000000 00000000 0 00 00000015

/* tb.f */
soc_pkg.sv
bus_decode.sv
sys_regs.sv
scratch_ram.sv
bus_return.sv
soc_fabric.sv
tb_checker.sv
tb_top.sv

/* Makefile */
# verilator flow for the memory-bus fabric testbench
VERILATOR = verilator
VFLAGS    = --timing --timescale 1ns/1ps --assert
LINTFLAGS = -Wall
TOP       = tb_top
FILELIST  = tb.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "simulation reported a failure"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
